// File: common/cache_pkg.sv
package cache_pkg;

    // cache geometry
    localparam int DATA_WIDTH       = 32;   // word size
    localparam int TAG_SIZE         = 21;
    localparam int CACHE_ADDR_WIDTH = 9;    // set index width
    localparam int BYTE_OFFSET      = 2;
    localparam int RAM_ADDR_WIDTH   = 32;
    localparam int NUM_SETS         = 512;

    // lru + 2 x (valid, dirty, tag, data) = 1 + 2 * (1 + 1 + 21 + 32)
    localparam int SET_SIZE         = 111;

    // word index into main memory, taken from address bits 13..2
    localparam int MEM_ADDR_WIDTH   = 12;

    typedef logic [DATA_WIDTH-1:0]       word_t;
    typedef logic [TAG_SIZE-1:0]         tag_t;
    typedef logic [CACHE_ADDR_WIDTH-1:0] set_idx_t;

    // one way of a set
    typedef struct packed {
        logic  valid;
        logic  dirty;   // word differs from main memory
        tag_t  tag;
        word_t data;
    } way_t;

    // field view of a set line, msb first
    typedef struct packed {
        logic lru;      // 1 when way 1 is the next victim
        way_t way1;
        way_t way0;
    } set_fields_t;

    // stored as a flat vector, decoded by field in the controller
    typedef union packed {
        logic [SET_SIZE-1:0] raw;
        set_fields_t         fields;
    } set_line_u;

endpackage

// File: common/axi_lite_pkg.sv
package axi_lite_pkg;

    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 32;

    typedef logic [1:0] resp_t;

    // only okay is ever returned by this slave
    localparam resp_t RESP_OKAY = 2'b00;

endpackage

// File: common/cache_req_if.sv
`timescale 1ns/1ns

interface cache_req_if;
    import cache_pkg::*;

    // request, one at a time
    logic                      req_valid;
    logic                      req_ready;
    logic                      req_we;      // 1 = write, 0 = read
    logic [RAM_ADDR_WIDTH-1:0] req_addr;
    word_t                     req_wdata;

    // single-cycle response pulse
    logic                      rsp_valid;
    word_t                     rsp_rdata;

    modport front (
        output req_valid,
        output req_we,
        output req_addr,
        output req_wdata,
        input  req_ready,
        input  rsp_valid,
        input  rsp_rdata
    );

    modport back (
        input  req_valid,
        input  req_we,
        input  req_addr,
        input  req_wdata,
        output req_ready,
        output rsp_valid,
        output rsp_rdata
    );

endinterface

// File: rtl/axi_lite_slave.sv
`timescale 1ns/1ns

module axi_lite_slave (
    input  logic                                clk,
    input  logic                                rst_n,

    // write address and data
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] wdata,
    input  logic                                wvalid,
    output logic                                wready,

    // write response
    output axi_lite_pkg::resp_t                 bresp,
    output logic                                bvalid,
    input  logic                                bready,

    // read address and data
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] rdata,
    output axi_lite_pkg::resp_t                 rresp,
    output logic                                rvalid,
    input  logic                                rready,

    cache_req_if.front                          req
);
    import axi_lite_pkg::*;

    enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT, ST_RESP} state;

    logic                      wr_accept;
    logic                      rd_accept;
    logic                      we_q;
    logic [AXI_ADDR_WIDTH-1:0] addr_q;
    logic [AXI_DATA_WIDTH-1:0] wdata_q;

    // write wins when both are pending
    assign wr_accept = (state == ST_IDLE) && awvalid && wvalid;
    assign rd_accept = (state == ST_IDLE) && arvalid && !(awvalid && wvalid);

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign arready = rd_accept;

    assign bvalid = (state == ST_RESP) && we_q;
    assign rvalid = (state == ST_RESP) && !we_q;
    assign bresp  = RESP_OKAY;
    assign rresp  = RESP_OKAY;

    assign req.req_valid = (state == ST_REQ);
    assign req.req_we    = we_q;
    assign req.req_addr  = addr_q;
    assign req.req_wdata = wdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (wr_accept || rd_accept) state <= ST_REQ;
                ST_REQ:   if (req.req_ready) state <= ST_WAIT;
                ST_WAIT:  if (req.rsp_valid) state <= ST_RESP;
                ST_RESP:  if ((bvalid && bready) || (rvalid && rready)) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // captured request and read data
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            we_q    <= 1'b1;
            addr_q  <= awaddr;
            wdata_q <= wdata;
        end else if (rd_accept) begin
            we_q   <= 1'b0;
            addr_q <= araddr;
        end
        if (state == ST_WAIT && req.rsp_valid) begin
            rdata <= req.rsp_rdata;   // held stable while rvalid waits
        end
    end

endmodule

// File: cache/cache_set_array.sv
`timescale 1ns/1ns

module cache_set_array (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rd_en,
    input  cache_pkg::set_idx_t  rd_idx,
    output cache_pkg::set_line_u rd_line,
    input  logic                 wr_en,
    input  cache_pkg::set_idx_t  wr_idx,
    input  cache_pkg::set_line_u wr_line
);
    import cache_pkg::*;

    logic [SET_SIZE-1:0] lines [NUM_SETS];

    // reset leaves every way invalid with lru at 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                lines[i] <= '0;
            end
        end else if (wr_en) begin
            lines[wr_idx] <= wr_line.raw;   // whole line at once
        end
    end

    // registered read, output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_line.raw <= lines[rd_idx];
        end
    end

endmodule

// File: cache/two_way_cache_controller.sv
`timescale 1ns/1ns

module two_way_cache_controller (
    // access being served
    input  logic                                we,
    input  cache_pkg::word_t                    wd,
    input  cache_pkg::set_idx_t                 target_set,
    input  cache_pkg::tag_t                     target_tag,

    // stored line and refill word
    input  cache_pkg::set_line_u                set_data,
    input  cache_pkg::word_t                    rd_from_ram,

    output logic                                hit,
    output cache_pkg::word_t                    data_out,

    // line to commit
    output cache_pkg::set_line_u                updated_set_data,
    output logic                                we_cache,

    // victim write-back
    output cache_pkg::word_t                    evicted_word,
    output logic [cache_pkg::RAM_ADDR_WIDTH-1:0] evicted_ram_addr,
    output logic                                we_to_ram
);
    import cache_pkg::*;

    way_t       ways     [2];
    way_t       new_ways [2];
    logic [1:0] hits;
    logic       victim_way;
    logic       chosen_way;   // way that ends up holding the word

    assign ways[0] = set_data.fields.way0;
    assign ways[1] = set_data.fields.way1;

    assign hits[0] = ways[0].valid && (ways[0].tag == target_tag);
    assign hits[1] = ways[1].valid && (ways[1].tag == target_tag);
    assign hit     = |hits;

    // fill an empty way 1 first, otherwise follow lru
    assign victim_way = !ways[1].valid || set_data.fields.lru;

    assign we_to_ram        = !hit && ways[victim_way].valid && ways[victim_way].dirty;
    assign evicted_word     = ways[victim_way].data;
    assign evicted_ram_addr = {ways[victim_way].tag, target_set, {BYTE_OFFSET{1'b0}}};

    always_comb begin
        new_ways   = ways;
        chosen_way = hits[1];
        if (!hit) begin
            // refill the victim, clean until a write marks it
            chosen_way                  = victim_way;
            new_ways[victim_way].valid  = 1'b1;
            new_ways[victim_way].dirty  = 1'b0;
            new_ways[victim_way].tag    = target_tag;
            new_ways[victim_way].data   = rd_from_ram;
        end

        data_out = new_ways[chosen_way].data;

        if (we) begin
            new_ways[chosen_way].data  = wd;
            new_ways[chosen_way].dirty = 1'b1;
        end
    end

    // lru points away from the way just used
    assign updated_set_data.fields = '{
        lru:  ~chosen_way,
        way1: new_ways[1],
        way0: new_ways[0]
    };

    assign we_cache = (updated_set_data.raw != set_data.raw);

endmodule

// File: cache/cache_sequencer.sv
`timescale 1ns/1ns

module cache_sequencer (
    input  logic                                 clk,
    input  logic                                 rst_n,

    cache_req_if.back                            req,

    // set array
    output logic                                 rd_en,
    output cache_pkg::set_idx_t                  rd_idx,
    output logic                                 wr_en,
    output cache_pkg::set_idx_t                  wr_idx,
    output cache_pkg::set_line_u                 wr_line,
    input  cache_pkg::set_line_u                 rd_line,

    // main memory
    output logic                                 mem_en,
    output logic                                 mem_we,
    output logic [cache_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,
    output cache_pkg::word_t                     mem_wdata,
    input  cache_pkg::word_t                     mem_rdata
);
    import cache_pkg::*;

    enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_EVALUATE,
        ST_WRITEBACK,
        ST_REFILL,
        ST_COMMIT
    } state;

    logic                      refill_phase;  // 0: issue read, 1: data back
    logic                      we_q;
    logic [RAM_ADDR_WIDTH-1:0] addr_q;
    word_t                     wdata_q;
    set_line_u                 line_q;
    word_t                     refill_q;

    logic                      hit;
    logic                      we_to_ram;
    logic                      we_cache;
    word_t                     data_out;
    word_t                     evicted_word;
    logic [RAM_ADDR_WIDTH-1:0] evicted_ram_addr;
    set_line_u                 updated_line;

    two_way_cache_controller u_ctrl (
        .we               (we_q),
        .wd               (wdata_q),
        .target_set       (addr_q[BYTE_OFFSET +: CACHE_ADDR_WIDTH]),
        .target_tag       (addr_q[RAM_ADDR_WIDTH-1 -: TAG_SIZE]),
        .set_data         (line_q),
        .rd_from_ram      (refill_q),
        .hit              (hit),
        .data_out         (data_out),
        .updated_set_data (updated_line),
        .we_cache         (we_cache),
        .evicted_word     (evicted_word),
        .evicted_ram_addr (evicted_ram_addr),
        .we_to_ram        (we_to_ram)
    );

    assign req.req_ready = (state == ST_IDLE);
    assign req.rsp_valid = (state == ST_COMMIT);
    assign req.rsp_rdata = data_out;

    // set read starts with the accepted request
    assign rd_en   = (state == ST_IDLE) && req.req_valid;
    assign rd_idx  = req.req_addr[BYTE_OFFSET +: CACHE_ADDR_WIDTH];
    assign wr_en   = (state == ST_COMMIT) && we_cache;   // skip unchanged lines
    assign wr_idx  = addr_q[BYTE_OFFSET +: CACHE_ADDR_WIDTH];
    assign wr_line = updated_line;

    assign mem_en    = (state == ST_WRITEBACK) || (state == ST_REFILL && !refill_phase);
    assign mem_we    = (state == ST_WRITEBACK);
    assign mem_addr  = mem_we ? evicted_ram_addr[BYTE_OFFSET +: MEM_ADDR_WIDTH]
                              : addr_q[BYTE_OFFSET +: MEM_ADDR_WIDTH];
    assign mem_wdata = evicted_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            refill_phase <= 1'b0;
        end else begin
            case (state)
                ST_IDLE:     if (req.req_valid) state <= ST_LOOKUP;
                ST_LOOKUP:   state <= ST_EVALUATE;
                ST_EVALUATE: begin
                    if (hit)            state <= ST_COMMIT;
                    else if (we_to_ram) state <= ST_WRITEBACK;   // dirty victim first
                    else                state <= ST_REFILL;
                end
                ST_WRITEBACK: state <= ST_REFILL;
                ST_REFILL: begin
                    refill_phase <= !refill_phase;
                    if (refill_phase) state <= ST_COMMIT;
                end
                ST_COMMIT:   state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req.req_valid) begin
            we_q    <= req.req_we;
            addr_q  <= req.req_addr;
            wdata_q <= req.req_wdata;
        end
        if (state == ST_LOOKUP) line_q <= rd_line;
        if (state == ST_REFILL && refill_phase) refill_q <= mem_rdata;
    end

endmodule

// File: rtl/main_memory.sv
`timescale 1ns/1ns

module main_memory (
    input  logic                                 clk,
    input  logic                                 en,
    input  logic                                 we,
    input  logic [cache_pkg::MEM_ADDR_WIDTH-1:0] addr,
    input  cache_pkg::word_t                     wdata,
    output cache_pkg::word_t                     rdata
);
    import cache_pkg::*;

    word_t mem [2**MEM_ADDR_WIDTH];   // 4096 words, contents undefined at start

    // one port, write or registered read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: rtl/two_way_cache_top.sv
`timescale 1ns/1ns

module two_way_cache_top (
    input  logic                                    clk,
    input  logic                                    rst_n,

    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                                    awvalid,
    output logic                                    awready,
    input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] wdata,
    input  logic                                    wvalid,
    output logic                                    wready,
    output axi_lite_pkg::resp_t                     bresp,
    output logic                                    bvalid,
    input  logic                                    bready,

    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                                    arvalid,
    output logic                                    arready,
    output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] rdata,
    output axi_lite_pkg::resp_t                     rresp,
    output logic                                    rvalid,
    input  logic                                    rready
);
    import cache_pkg::*;

    logic                      rd_en;
    set_idx_t                  rd_idx;
    set_line_u                 rd_line;
    logic                      wr_en;
    set_idx_t                  wr_idx;
    set_line_u                 wr_line;

    logic                      mem_en;
    logic                      mem_we;
    logic [MEM_ADDR_WIDTH-1:0] mem_addr;
    word_t                     mem_wdata;
    word_t                     mem_rdata;

    cache_req_if req_if ();

    axi_lite_slave u_axi (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .req     (req_if.front)
    );

    cache_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req_if.back),
        .rd_en     (rd_en),
        .rd_idx    (rd_idx),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_line   (wr_line),
        .rd_line   (rd_line),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    cache_set_array u_sets (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_line (rd_line),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_line (wr_line)
    );

    main_memory u_mem (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// File: testbench/tb_two_way_cache.sv
`timescale 1ns/1ns

module tb_two_way_cache;
    import cache_pkg::*;
    import axi_lite_pkg::*;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int NUM_RANDOM_OPS = 400;

    logic                      clk;
    logic                      rst_n;
    logic [AXI_ADDR_WIDTH-1:0] awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [AXI_DATA_WIDTH-1:0] wdata;
    logic                      wvalid;
    logic                      wready;
    resp_t                     bresp;
    logic                      bvalid;
    logic                      bready;
    logic [AXI_ADDR_WIDTH-1:0] araddr;
    logic                      arvalid;
    logic                      arready;
    logic [AXI_DATA_WIDTH-1:0] rdata;
    resp_t                     rresp;
    logic                      rvalid;
    logic                      rready;

    integer   seed;
    string    test_name;
    word_t    model_mem   [2**MEM_ADDR_WIDTH];   // flat memory, by word address
    bit       model_valid [2**MEM_ADDR_WIDTH];
    set_idx_t test_sets   [4];

    two_way_cache_top dut (.*);

    always #50 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("Error %s %s: expected %h, actual %h",
                               test_name, what, expected, actual));
        end
    endtask

    task automatic check_resp(input string what, input resp_t expected, input resp_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("Error %s %s: expected %b, actual %b",
                               test_name, what, expected, actual));
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_run($sformatf("Error %s %s: expected %b, actual %b",
                               test_name, what, expected, actual));
        end
    endtask

    // tag below bit 14 keeps every address inside main memory
    function automatic logic [AXI_ADDR_WIDTH-1:0] make_addr(input int tag_sel, input int set_sel);
        logic [AXI_ADDR_WIDTH-1:0] a;
        a = '0;
        a[BYTE_OFFSET +: CACHE_ADDR_WIDTH]     = test_sets[set_sel];
        a[BYTE_OFFSET + CACHE_ADDR_WIDTH +: 3] = 3'(tag_sel);
        return a;
    endfunction

    function automatic int word_index(input logic [AXI_ADDR_WIDTH-1:0] addr);
        return int'(addr[BYTE_OFFSET +: MEM_ADDR_WIDTH]);
    endfunction

    task automatic axi_write(input logic [AXI_ADDR_WIDTH-1:0] addr, input word_t data);
        int waited;
        int delay;
        delay = $unsigned($random(seed)) % 3;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        @(posedge clk);
        while (!(awready && wready)) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                stop_run("write address and data channels never answered");
            end
            @(posedge clk);
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (delay) @(negedge clk);
        bready = 1'b1;
        waited = 0;
        @(posedge clk);
        while (!bvalid) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) stop_run("write response channel never answered");
            @(posedge clk);
        end
        check_resp("bresp", RESP_OKAY, bresp);
        @(negedge clk);
        bready = 1'b0;
        model_mem[word_index(addr)]   = data;
        model_valid[word_index(addr)] = 1'b1;
    endtask

    // stall holds rready low that many cycles; press drives competing requests meanwhile
    task automatic axi_read(input logic [AXI_ADDR_WIDTH-1:0] addr, input int stall, input bit press);
        int    waited;
        word_t first;
        word_t expected;
        expected = model_mem[word_index(addr)];
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        @(posedge clk);
        while (!arready) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) stop_run("read address channel never answered");
            @(posedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        waited  = 0;
        @(posedge clk);
        while (!rvalid) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) stop_run("read data channel never answered");
            @(posedge clk);
        end
        first = rdata;
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            if (press) begin
                awaddr  = make_addr(7, 0);
                wdata   = $random(seed);
                awvalid = 1'b1;
                wvalid  = 1'b1;
                araddr  = make_addr(6, 0);
                arvalid = 1'b1;
            end
            @(posedge clk);
            check_flag("rvalid held", 1'b1, rvalid);
            check_word("rdata held", first, rdata);
            check_flag("awready during stall", 1'b0, awready);
            check_flag("wready during stall", 1'b0, wready);
            check_flag("arready during stall", 1'b0, arready);
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(posedge clk);
        check_flag("rvalid at handshake", 1'b1, rvalid);
        check_word("rdata", expected, rdata);
        check_resp("rresp", RESP_OKAY, rresp);
        @(negedge clk);
        rready = 1'b0;
    endtask

    initial begin
        logic [31:0]               r;
        logic [AXI_ADDR_WIDTH-1:0] addr;
        seed    = 7512;
        clk     = 1'b0;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int i = 0; i < 2**MEM_ADDR_WIDTH; i++) begin
            model_valid[i] = 1'b0;
        end
        test_sets[0] = 9'd3;
        test_sets[1] = 9'd77;
        test_sets[2] = 9'd200;
        test_sets[3] = 9'd511;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_name = "reset";
        check_flag("awready", 1'b0, awready);
        check_flag("wready", 1'b0, wready);
        check_flag("arready", 1'b0, arready);
        check_flag("bvalid", 1'b0, bvalid);
        check_flag("rvalid", 1'b0, rvalid);

        test_name = "write then read";
        axi_write(make_addr(0, 0), $random(seed));   // write miss allocates
        axi_read(make_addr(0, 0), 0, 1'b0);          // read hit

        // third tag evicts a dirty way, later reads pull it back from memory
        test_name = "three tags in one set";
        for (int t = 0; t < 3; t++) axi_write(make_addr(t, 1), $random(seed));
        for (int t = 0; t < 3; t++) axi_read(make_addr(t, 1), 0, 1'b0);

        test_name = "overwrite then evict";
        axi_write(make_addr(3, 3), $random(seed));
        axi_write(make_addr(4, 3), $random(seed));
        axi_write(make_addr(5, 3), $random(seed));
        axi_write(make_addr(6, 3), $random(seed));
        axi_read(make_addr(3, 3), 0, 1'b0);          // clean refill into way 1
        axi_read(make_addr(4, 3), 0, 1'b0);          // clean refill into way 0
        axi_write(make_addr(4, 3), $random(seed));   // hit in way 0
        axi_write(make_addr(3, 3), $random(seed));   // hit in way 1
        axi_write(make_addr(5, 3), $random(seed));
        axi_write(make_addr(6, 3), $random(seed));
        axi_read(make_addr(3, 3), 0, 1'b0);
        axi_read(make_addr(4, 3), 0, 1'b0);

        test_name = "read stall";
        axi_write(make_addr(2, 2), $random(seed));
        axi_read(make_addr(2, 2), 1 + ($unsigned($random(seed)) % 6), 1'b1);

        test_name = "random traffic";
        for (int n = 0; n < NUM_RANDOM_OPS; n++) begin
            r    = $random(seed);
            addr = make_addr(r[2:0], r[4:3]);
            if (r[5] || !model_valid[word_index(addr)]) begin
                axi_write(addr, $random(seed));
            end else begin
                axi_read(addr, r[7:6], 1'b0);
            end
        end

        // sweep every written address once more
        test_name = "final sweep";
        for (int s = 0; s < 4; s++) begin
            for (int t = 0; t < 8; t++) begin
                if (model_valid[word_index(make_addr(t, s))]) axi_read(make_addr(t, s), 0, 1'b0);
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: sim.f
common/cache_pkg.sv
common/axi_lite_pkg.sv
common/cache_req_if.sv
rtl/axi_lite_slave.sv
cache/cache_set_array.sv
cache/two_way_cache_controller.sv
cache/cache_sequencer.sv
rtl/main_memory.sv
rtl/two_way_cache_top.sv
testbench/tb_two_way_cache.sv

// File: Bender.yml
package:
  name: two_way_cache

sources:
  - common/cache_pkg.sv
  - common/axi_lite_pkg.sv
  - common/cache_req_if.sv
  - rtl/axi_lite_slave.sv
  - cache/cache_set_array.sv
  - cache/two_way_cache_controller.sv
  - cache/cache_sequencer.sv
  - rtl/main_memory.sv
  - rtl/two_way_cache_top.sv
  - target: simulation
    files:
      - testbench/tb_two_way_cache.sv
